/* hw/fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// address width in bits
`define FETCH_AW 32

// cache block size in bytes (four words)
`define FETCH_BLOCK_BYTES 16

// direct-mapped lines
`define FETCH_LINES 8

// rom depth in words before addresses wrap
`define FETCH_ROM_WORDS 256

`endif

/* hw/fetch_pkg.sv */
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

    localparam int BLOCK_WORDS = `FETCH_BLOCK_BYTES / 4;
    localparam int OFF_BITS    = $clog2(BLOCK_WORDS);
    localparam int IDX_BITS    = $clog2(`FETCH_LINES);
    localparam int ROM_AW      = $clog2(`FETCH_ROM_WORDS);
    localparam int TAG_BITS    = `FETCH_AW - IDX_BITS - OFF_BITS - 2;

    typedef logic [31:0] word_t;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [IDX_BITS-1:0] index;
        logic [OFF_BITS-1:0] offset;  // word within block
        logic [1:0]          zero;
    } addr_fields_t;

    // cache side reads the fields, bus side the raw word
    typedef union packed {
        logic [`FETCH_AW-1:0] raw;
        addr_fields_t         f;
    } fetch_addr_u;

    typedef struct packed {
        logic [`FETCH_AW-1:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic [`FETCH_AW-1:0] pc;
        word_t                inst;
    } fetch_resp_t;

    typedef struct packed {
        logic [`FETCH_AW-1:0] araddr;
    } axi_ar_t;

    typedef struct packed {
        word_t      rdata;
        logic [1:0] rresp;
    } axi_r_t;

    typedef logic [BLOCK_WORDS-1:0][31:0] cache_line_t;

    // content of the word at byte address addr after wrapping to the rom depth
    // w * const ^ rotl(w, 7) with w the word index
    function automatic word_t rom_word(input logic [`FETCH_AW-1:0] addr);
        word_t w;
        w = 32'(addr[ROM_AW+1:2]);
        return (w * 32'h9e37_79b1) ^ {w[24:0], w[31:25]};
    endfunction

endpackage

`default_nettype wire

/* hw/icache.sv */
`default_nettype none

`include "fetch_settings.svh"

module icache import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        lookup,
    input  fetch_addr_u lookup_addr,
    output logic        hit,
    output word_t       hit_data,
    input  logic        fill,
    input  fetch_addr_u fill_addr,
    input  cache_line_t fill_line
);

    logic [`FETCH_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]     tag_mem  [`FETCH_LINES];
    cache_line_t             data_mem [`FETCH_LINES];

    logic        tag_match;
    cache_line_t rd_line;

    assign rd_line   = data_mem[lookup_addr.f.index];
    assign tag_match = valid_q[lookup_addr.f.index]
                    && (tag_mem[lookup_addr.f.index] == lookup_addr.f.tag);

    // ====================
    // fill
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_addr.f.index] <= 1'b1;
        end
    end

    // old line is simply overwritten on a tag conflict
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_mem[fill_addr.f.index]  <= fill_addr.f.tag;
            data_mem[fill_addr.f.index] <= fill_line;
        end
    end

    // ====================
    // lookup
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= lookup && tag_match;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            hit_data <= rd_line[lookup_addr.f.offset];  // word select
        end
    end

endmodule

`default_nettype wire

/* hw/inst_rom.sv */
`default_nettype none

`include "fetch_settings.svh"

module inst_rom import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    ar_valid,
    input  axi_ar_t ar,
    output logic    ar_ready,
    output logic    r_valid,
    output axi_r_t  r,
    input  logic    r_ready
);

    word_t             rom_table [`FETCH_ROM_WORDS];
    logic [ROM_AW-1:0] word_idx;

    // constant table with one entry per word address
    for (genvar i = 0; i < `FETCH_ROM_WORDS; i++) begin : g_table
        localparam logic [`FETCH_AW-1:0] ADDR = i * 4;
        assign rom_table[i] = rom_word(ADDR);
    end

    assign word_idx = ar.araddr[ROM_AW+1:2];  // upper bits wrap
    assign ar_ready = !r_valid;              // one beat in flight

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r.rdata <= rom_table[word_idx];
            r.rresp <= 2'b00;
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // request / response
    input  logic        req_valid,
    input  fetch_req_t  req,
    output logic        req_ready,
    output logic        resp_valid,
    output fetch_resp_t resp,
    input  logic        resp_ready,
    // cache
    output logic        lookup,
    output fetch_addr_u lookup_addr,
    input  logic        hit,
    input  word_t       hit_data,
    output logic        fill,
    output fetch_addr_u fill_addr,
    output cache_line_t fill_line,
    // axi read channels
    output logic        ar_valid,
    output axi_ar_t     ar,
    input  logic        ar_ready,
    input  logic        r_valid,
    input  axi_r_t      r,
    output logic        r_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CHECK,
        S_REFILL,
        S_RESPOND
    } state_t;

    state_t              state;
    fetch_addr_u         pc_q;
    cache_line_t         line_q;
    cache_line_t         line_next;
    logic [OFF_BITS-1:0] beat;

    logic accept;
    logic ar_fire;
    logic r_fire;
    logic beat_ok;
    logic last_beat;

    // address of one word of the pending block
    function automatic fetch_addr_u beat_addr(input logic [OFF_BITS-1:0] b);
        fetch_addr_u a;
        a = pc_q;
        a.f.offset = b;
        a.f.zero = 2'b00;
        return a;
    endfunction

    assign accept    = req_valid && req_ready;
    assign ar_fire   = ar_valid && ar_ready;
    assign r_fire    = r_valid && r_ready;
    assign beat_ok   = r_fire && (r.rresp == 2'b00);  // error beats are dropped
    assign last_beat = (beat == OFF_BITS'(BLOCK_WORDS - 1));

    assign lookup_addr = pc_q;
    assign fill_addr   = pc_q;
    assign fill_line   = line_q;

    always_comb begin
        line_next = line_q;
        line_next[beat] = r.rdata;
    end

    // ====================
    // control
    // ====================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            req_ready  <= 1'b0;
            resp_valid <= 1'b0;
            lookup     <= 1'b0;
            fill       <= 1'b0;
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            beat       <= '0;
        end else begin
            fill <= 1'b0;
            case (state)
                S_IDLE: begin
                    req_ready <= !accept;  // rises one cycle after reset
                    if (accept) begin
                        lookup <= 1'b1;
                        state  <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (lookup) begin
                        lookup <= 1'b0;  // cache samples this cycle
                    end else if (hit) begin
                        resp_valid <= 1'b1;
                        state      <= S_RESPOND;
                    end else begin
                        ar_valid <= 1'b1;
                        beat     <= '0;
                        state    <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (ar_fire) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (r_fire) begin
                        r_ready <= 1'b0;
                        if (beat_ok && last_beat) begin
                            fill       <= 1'b1;
                            resp_valid <= 1'b1;
                            state      <= S_RESPOND;
                        end else begin
                            ar_valid <= 1'b1;  // next beat, or same one again
                            if (beat_ok) begin
                                beat <= beat + 1'b1;
                            end
                        end
                    end
                end
                S_RESPOND: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        req_ready  <= 1'b1;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ====================
    // payload
    // ====================
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q.raw <= req.pc;
        end
        if (state == S_CHECK && !lookup) begin
            resp.pc   <= pc_q.raw;
            resp.inst <= hit_data;
            ar.araddr <= beat_addr('0);  // block base
        end
        if (state == S_REFILL && beat_ok) begin
            line_q <= line_next;
            if (last_beat) begin
                resp.inst <= line_next[pc_q.f.offset];  // no second lookup
            end else begin
                ar.araddr <= beat_addr(beat + 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  fetch_req_t  req,
    output logic        req_ready,
    output logic        resp_valid,
    output fetch_resp_t resp,
    input  logic        resp_ready
);

    // cache port
    logic        lookup;
    fetch_addr_u lookup_addr;
    logic        hit;
    word_t       hit_data;
    logic        fill;
    fetch_addr_u fill_addr;
    cache_line_t fill_line;

    // rom read channels
    logic    ar_valid;
    axi_ar_t ar;
    logic    ar_ready;
    logic    r_valid;
    axi_r_t  r;
    logic    r_ready;

    fetch_unit u_unit (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready),
        .lookup     (lookup),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .hit_data   (hit_data),
        .fill       (fill),
        .fill_addr  (fill_addr),
        .fill_line  (fill_line),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r          (r),
        .r_ready    (r_ready)
    );

    icache u_cache (
        .clk        (clk),
        .rst        (rst),
        .lookup     (lookup),
        .lookup_addr(lookup_addr),
        .hit        (hit),
        .hit_data   (hit_data),
        .fill       (fill),
        .fill_addr  (fill_addr),
        .fill_line  (fill_line)
    );

    inst_rom u_rom (
        .clk     (clk),
        .rst     (rst),
        .ar_valid(ar_valid),
        .ar      (ar),
        .ar_ready(ar_ready),
        .r_valid (r_valid),
        .r       (r),
        .r_ready (r_ready)
    );

endmodule

`default_nettype wire

/* bench/fetch_chk.sv */
`default_nettype none

module fetch_chk import fetch_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        req_ready,
    input logic        resp_valid,
    input fetch_resp_t resp,
    input logic        resp_ready,
    input logic        ar_valid,
    input axi_ar_t     ar,
    input logic        ar_ready,
    input logic        r_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;  // read by the testbench

    // ====================
    // handshakes
    // ====================
    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && resp == $past(resp))
    else begin
        failures++;
        $error("resp changed while stalled");
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && ar == $past(ar))
    else begin
        failures++;
        $error("ar changed while stalled");
    end

    // one fetch at a time
    busy_no_req: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !req_ready)
    else begin
        failures++;
        $error("req_ready high with a response pending");
    end

    // ====================
    // reset
    // ====================
    reset_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !(req_ready || resp_valid || ar_valid || r_ready))
    else begin
        failures++;
        $error("outputs not low out of reset");
    end

endmodule

`default_nettype wire

/* bench/fetch_tb.sv */
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int N_SEQ        = 32;
    localparam int N_ALT        = 12;
    localparam int N_RAND       = 200;
    localparam int N_REQ        = 2 * N_SEQ + N_ALT + N_RAND;
    // accept, lookup, check, four beats of two cycles, respond, a little stall
    localparam int MISS_CYCLES    = 20;
    localparam int TIMEOUT_CYCLES = 2 * MISS_CYCLES * N_REQ + RESET_CYCLES;

    localparam logic [31:0] LFSR_SEED = 32'he713_b54b;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam logic [31:0] PC_A      = 32'h0000_0120;  // index 2, tag 2
    localparam logic [31:0] PC_B      = 32'h0000_01a0;  // index 2, tag 3

    localparam int T_ANY  = 0;
    localparam int T_HIT  = 1;
    localparam int T_MISS = 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    fetch_req_t  req;
    logic        req_ready;
    logic        resp_valid;
    fetch_resp_t resp;
    logic        resp_ready;

    logic [31:0] lfsr_state;
    logic [31:0] pending_pc[$];
    int          timing_mode     = 0;
    int          accept_count    = 0;
    int          resp_count      = 0;
    int          edge_count      = 0;
    int          accept_edge     = 0;
    int          timeout_count   = 0;
    logic        resp_valid_prev = 1'b0;

    fetch_top dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .resp_valid(resp_valid),
        .resp      (resp),
        .resp_ready(resp_ready)
    );

    bind fetch_unit fetch_chk u_chk (
        .clk       (clk),
        .rst       (rst),
        .req_ready (req_ready),
        .resp_valid(resp_valid),
        .resp      (resp),
        .resp_ready(resp_ready),
        .ar_valid  (ar_valid),
        .ar        (ar),
        .ar_ready  (ar_ready),
        .r_ready   (r_ready)
    );

    always #HALF_PERIOD clk = ~clk;

    // ====================
    // helpers
    // ====================
    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0d ns %s: got %08h, expected %08h", $time, what, got, want);
            abort_run();
        end
    endtask

    // word index times a constant xor the index rotated left by 7
    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        logic [31:0] idx;
        idx = {2'b00, pc[31:2]} % `FETCH_ROM_WORDS;  // rom wraps at its depth
        return (idx * 32'h9e37_79b1) ^ {idx[24:0], idx[31:25]};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // hold one request until accepted and wait for its response
    task automatic fetch_one(input logic [31:0] pc, input logic stall);
        int          acc_target;
        int          resp_target;
        logic [31:0] bits;
        acc_target  = accept_count + 1;
        resp_target = resp_count + 1;
        req_valid   = 1'b1;
        req.pc      = pc;
        while (resp_count < resp_target) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (accept_count >= acc_target) begin
                req_valid = 1'b0;
            end
            if (stall) begin
                draw_bits(2, bits);
                resp_ready = (bits[1:0] != 2'b00);  // drop one cycle in four
            end else begin
                resp_ready = 1'b1;
            end
        end
    endtask

    // ====================
    // compare and timeout
    // ====================
    always @(posedge clk) begin
        int          latency;
        logic [31:0] exp_pc;
        edge_count++;
        if (!rst) begin
            check_value("bound assertion failures", 32'(dut.u_unit.u_chk.failures), 0);
            if (req_valid && req_ready) begin
                pending_pc.push_back(req.pc);
                accept_count++;
                accept_edge = edge_count;
            end
            if (resp_valid && !resp_valid_prev) begin
                latency = edge_count - 1 - accept_edge;  // it rose on the previous edge
                if (timing_mode == T_HIT) begin
                    check_value("hit latency", 32'(latency), 2);
                end else if (timing_mode == T_MISS) begin
                    check_value("miss on conflicting tag", 32'(latency > 2), 1);
                end
            end
            if (resp_valid && resp_ready) begin
                check_value("outstanding requests", 32'(pending_pc.size()), 1);
                exp_pc = pending_pc.pop_front();
                check_value("resp pc", resp.pc, exp_pc);
                check_value("resp inst", resp.inst, expected_inst(exp_pc));
                resp_count++;
            end
        end
        resp_valid_prev = resp_valid;
    end

    always @(posedge clk) begin
        timeout_count++;
        if (timeout_count > TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ====================
    // stimulus
    // ====================
    initial begin
        logic [31:0] bits;
        int          wait_cycles;
        int          i;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        lfsr_state = LFSR_SEED;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        check_value("resp_valid in reset", 32'(resp_valid), 0);
        rst = 1'b0;
        wait_cycles = 0;
        while (!req_ready && wait_cycles < 3) begin
            @(posedge clk);
            #DRIVE_DELAY;
            wait_cycles++;
        end
        check_value("req_ready within two cycles", 32'(req_ready && wait_cycles <= 2), 1);
        check_value("resp_valid after reset", 32'(resp_valid), 0);

        for (i = 0; i < N_SEQ; i++) begin
            fetch_one(32'(i * 4), 1'b0);  // cold
        end
        timing_mode = T_HIT;
        for (i = 0; i < N_SEQ; i++) begin
            fetch_one(32'(i * 4), 1'b0);
        end
        timing_mode = T_MISS;
        for (i = 0; i < N_ALT; i++) begin
            fetch_one(((i % 2 == 0) ? PC_A : PC_B) + 32'((i / 2) % 4 * 4), 1'b0);
        end
        timing_mode = T_ANY;
        for (i = 0; i < N_RAND; i++) begin
            draw_bits(10, bits);
            fetch_one({20'h0, bits[9:0], 2'b00}, 1'b1);
        end

        // quiet stretch where any response would have no request
        resp_ready = 1'b1;
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        check_value("bound assertion failures", 32'(dut.u_unit.u_chk.failures), 0);
        if (accept_count == N_REQ && resp_count == N_REQ && pending_pc.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("request and response counts do not match: %0d accepted, %0d answered",
                     accept_count, resp_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/fetch_pkg.sv
hw/icache.sv
hw/inst_rom.sv
hw/fetch_unit.sv
hw/fetch_top.sv
bench/fetch_chk.sv
bench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the fetch path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fetch_tb -f sim.f

# assertion errors must not stop the run before the testbench reports them
./obj_dir/Vfetch_tb +verilator+error+limit+100 | tee sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass, see sim.log"
    exit 1
fi
